//--- tile_board_top.f
verilog/tile_sys_pkg.sv
verilog/wb_to_axi_bridge.sv
verilog/rmii_mii_adapter.sv
verilog/dbg_ctrl_apb.sv
verilog/tile_board_top.sv
dv/tb_tile_board_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_tile_board_top
FILELIST  ?= tile_board_top.f
LOG       ?= sim.log
PASS_MSG  := \*\*\* TEST PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_tile_board_top.sv
// Testbench for tile_board_top with LFSR stimulus, bus models, reference models and checks
`timescale 1ns/1ps

module tb_tile_board_top;

   logic                   clk_i;
   logic                   rst_i;
   tile_sys_pkg::wb_req_t  wb_req;
   tile_sys_pkg::wb_rsp_t  wb_rsp_o;
   tile_sys_pkg::axi_ax_t  aw_o;
   tile_sys_pkg::axi_ax_t  ar_o;
   tile_sys_pkg::axi_w_t   w_o;
   tile_sys_pkg::axi_b_t   b_i;
   tile_sys_pkg::axi_r_t   r_i;
   logic                   awvalid_o, awready_i, wvalid_o, wready_i;
   logic                   bvalid_i, bready_o, arvalid_o, arready_i;
   logic                   rvalid_i, rready_o;
   logic                   rmii_crsdv_i, rmii_rxerr_i;
   logic [1:0]             rmii_rxd_i, rmii_txd_o;
   logic                   rmii_txen_o;
   logic [3:0]             mii_rxd_o, mii_txd_i;
   logic                   mii_rx_dv_o, mii_rx_er_o, mii_tx_en_i, mii_tx_stb_o;
   tile_sys_pkg::apb_req_t apb_req;
   tile_sys_pkg::apb_rsp_t apb_rsp_o;
   logic                   rst_sys_o, rst_cpu_o;

   logic [15:0] lfsr_q = 16'd53482;
   int          err_cnt = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   // Sparse DRAM model keyed by byte address
   logic [31:0] mem [logic [27:0]];
   logic [27:0] wr_addrs [$];

   tile_board_top u_dut (
      .clk_i(clk_i), .rst_i(rst_i), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp_o),
      .aw_o(aw_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
      .w_o(w_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
      .b_i(b_i), .bvalid_i(bvalid_i), .bready_o(bready_o),
      .ar_o(ar_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
      .r_i(r_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
      .rmii_crsdv_i(rmii_crsdv_i), .rmii_rxerr_i(rmii_rxerr_i), .rmii_rxd_i(rmii_rxd_i),
      .rmii_txd_o(rmii_txd_o), .rmii_txen_o(rmii_txen_o),
      .mii_rxd_o(mii_rxd_o), .mii_rx_dv_o(mii_rx_dv_o), .mii_rx_er_o(mii_rx_er_o),
      .mii_txd_i(mii_txd_i), .mii_tx_en_i(mii_tx_en_i), .mii_tx_stb_o(mii_tx_stb_o),
      .apb_req_i(apb_req), .apb_rsp_o(apb_rsp_o),
      .rst_sys_o(rst_sys_o), .rst_cpu_o(rst_cpu_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   // Unwritten DRAM content
   function automatic logic [31:0] fill_word(input logic [27:0] a);
      return {a[3:0], a} ^ {a[15:0], a[27:12]} ^ 32'h5A5A_0F0F;
   endfunction

   function automatic logic [31:0] mem_read(input logic [27:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return fill_word(a);
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
      err_cnt++;
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR time=%0t %s", $time, msg);
      err_cnt++;
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      if (err_cnt == errs_at_start) begin
         tests_passed++;
         $display("Test %s: PASS", name);
      end else begin
         tests_failed++;
         $display("Test %s: FAIL with %0d errors", name, err_cnt - errs_at_start);
      end
   endtask

   task automatic check_ax(input string sig, input tile_sys_pkg::axi_ax_t ax,
                           input logic [27:0] adr);
      if (ax.addr != adr) report_mismatch({sig, ".addr"}, 32'(adr), 32'(ax.addr));
      if (ax.id != 4'd0) report_mismatch({sig, ".id"}, 32'd0, 32'(ax.id));
      if (ax.len != 8'd0) report_mismatch({sig, ".len"}, 32'd0, 32'(ax.len));
      if (ax.size != 3'd2) report_mismatch({sig, ".size"}, 32'd2, 32'(ax.size));
      if (ax.burst != 2'd1) report_mismatch({sig, ".burst"}, 32'd1, 32'(ax.burst));
   endtask

   // One Wishbone access with the AXI slave model answering under random delays
   task automatic wb_access(input logic we, input logic [27:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      tile_sys_pkg::wb_req_t req;
      int          aw_dly, w_dly, rsp_dly, aw_cnt, w_cnt, rsp_cnt, cyc;
      logic        aw_hs, w_hs, ar_hs, rsp_hs, rsp_ready, ended, is_err;
      logic [31:0] exp_rd, merged;
      is_err  = adr[27];
      aw_dly  = int'(lfsr_bits(2));
      w_dly   = int'(lfsr_bits(2));
      rsp_dly = int'(lfsr_bits(2));
      exp_rd  = mem_read(adr);
      aw_cnt  = 0;
      w_cnt   = 0;
      rsp_cnt = 0;
      cyc     = 0;
      aw_hs   = 1'b0;
      w_hs    = 1'b0;
      ar_hs   = 1'b0;
      rsp_hs  = 1'b0;
      ended   = 1'b0;
      req     = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      @(posedge clk_i);
      wb_req <= req;
      while (!ended && cyc < 200) begin
         @(negedge clk_i);
         cyc++;
         if (!we && (awvalid_o || wvalid_o)) report_failure("write channel active on a read");
         if (we && arvalid_o) report_failure("AR valid raised on a write");
         if (aw_hs && awvalid_o) report_failure("AW valid still high after its handshake");
         if (w_hs && wvalid_o) report_failure("W valid still high after its handshake");
         if (ar_hs && arvalid_o) report_failure("new AR issued before the access ended");
         if (awvalid_o && awready_i && !aw_hs) begin
            aw_hs = 1'b1;
            check_ax("aw", aw_o, adr);
         end else if (awvalid_o) begin
            aw_cnt++;
         end
         if (wvalid_o && wready_i && !w_hs) begin
            w_hs = 1'b1;
            if (w_o.data != dat) report_mismatch("w.data", dat, w_o.data);
            if (w_o.strb != sel) report_mismatch("w.strb", 32'(sel), 32'(w_o.strb));
            if (w_o.last != 1'b1) report_mismatch("w.last", 32'd1, 32'(w_o.last));
            if (!is_err) begin
               merged = mem_read(adr);
               for (int i = 0; i < 4; i++) begin
                  if (w_o.strb[i]) merged[8*i +: 8] = w_o.data[8*i +: 8];
               end
               mem[adr] = merged;
            end
         end else if (wvalid_o) begin
            w_cnt++;
         end
         if (arvalid_o && arready_i && !ar_hs) begin
            ar_hs = 1'b1;
            check_ax("ar", ar_o, adr);
         end else if (arvalid_o) begin
            aw_cnt++;
         end
         rsp_ready = we ? (aw_hs && w_hs) : ar_hs;
         if ((we && bvalid_i && bready_o) || (!we && rvalid_i && rready_o)) begin
            rsp_hs = 1'b1;
         end else if (rsp_ready) begin
            rsp_cnt++;
         end
         if (wb_rsp_o.ack || wb_rsp_o.err) begin
            ended = 1'b1;
            if (!rsp_hs) report_failure("Wishbone ended before the AXI response");
            if (wb_rsp_o.ack != !is_err) begin
               report_mismatch("wb.ack", 32'(!is_err), 32'(wb_rsp_o.ack));
            end
            if (wb_rsp_o.err != is_err) begin
               report_mismatch("wb.err", 32'(is_err), 32'(wb_rsp_o.err));
            end
            if (!we && wb_rsp_o.ack && wb_rsp_o.dat != exp_rd) begin
               report_mismatch("wb.dat", exp_rd, wb_rsp_o.dat);
            end
         end
         @(posedge clk_i);
         awready_i  <= !aw_hs && aw_cnt >= aw_dly;
         wready_i   <= !w_hs && w_cnt >= w_dly;
         arready_i  <= !ar_hs && aw_cnt >= aw_dly;
         bvalid_i   <= we && rsp_ready && !rsp_hs && rsp_cnt >= rsp_dly;
         b_i        <= '{id: 4'd0, resp: is_err ? 2'b10 : 2'b00};
         rvalid_i   <= !we && rsp_ready && !rsp_hs && rsp_cnt >= rsp_dly;
         r_i        <= '{id: 4'd0, data: exp_rd, resp: is_err ? 2'b10 : 2'b00, last: 1'b1};
         if (ended) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
         end
      end
      if (!ended) begin
         report_failure("timeout waiting for Wishbone ack or err");
         wb_req.cyc <= 1'b0;
         wb_req.stb <= 1'b0;
      end
      @(negedge clk_i);
      if (wb_rsp_o.ack || wb_rsp_o.err) report_failure("ack or err high for more than one cycle");
   endtask

   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic slverr);
      tile_sys_pkg::apb_req_t req;
      int                     waits;
      req   = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
      waits = 0;
      @(posedge clk_i);
      apb_req <= req;
      req.penable = 1'b1;
      @(posedge clk_i);
      apb_req <= req;
      @(negedge clk_i);
      while (!apb_rsp_o.pready && waits < 16) begin
         @(negedge clk_i);
         waits++;
      end
      if (!apb_rsp_o.pready) report_failure("timeout waiting for APB pready");
      rdata  = apb_rsp_o.prdata;
      slverr = apb_rsp_o.pslverr;
      @(posedge clk_i);
      apb_req <= '0;
   endtask

   task automatic ctrl_write(input logic [1:0] bits);
      logic [31:0] rd;
      logic        se;
      apb_xfer(1'b1, tile_sys_pkg::REG_CTRL, {30'd0, bits}, rd, se);
      @(negedge clk_i);
      if (se) report_failure("slave error on a CTRL write");
      if (rst_sys_o != bits[0]) report_mismatch("rst_sys_o", 32'(bits[0]), 32'(rst_sys_o));
      if (rst_cpu_o != bits[1]) report_mismatch("rst_cpu_o", 32'(bits[1]), 32'(rst_cpu_o));
   endtask

   task automatic rmii_rx_frame(input int nbytes);
      logic [1:0] dib [$];
      logic       er [$];
      logic [3:0] exp_nib [$];
      logic       exp_er [$];
      logic [3:0] got_nib [$];
      logic       got_er [$];
      logic [7:0] b;
      for (int i = 0; i < nbytes; i++) begin
         b = 8'(lfsr_bits(8));
         for (int k = 0; k < 4; k++) begin
            dib.push_back(b[2*k +: 2]);
            er.push_back(lfsr_bits(3) == 0);
         end
      end
      for (int j = 0; j < dib.size() / 2; j++) begin
         exp_nib.push_back({dib[2*j+1], dib[2*j]});
         exp_er.push_back(er[2*j] | er[2*j+1]);
      end
      // Lone trailing dibit before crsdv drops
      dib.push_back(2'(lfsr_bits(2)));
      er.push_back(1'b0);
      for (int i = 0; i < dib.size() + 4; i++) begin
         @(posedge clk_i);
         rmii_crsdv_i <= i < dib.size();
         rmii_rxd_i   <= (i < dib.size()) ? dib[i] : 2'b00;
         rmii_rxerr_i <= (i < dib.size()) ? er[i] : 1'b0;
         @(negedge clk_i);
         if (mii_rx_dv_o) begin
            got_nib.push_back(mii_rxd_o);
            got_er.push_back(mii_rx_er_o);
         end
      end
      if (got_nib.size() != exp_nib.size()) begin
         report_mismatch("rx nibble count", exp_nib.size(), got_nib.size());
      end else begin
         for (int j = 0; j < exp_nib.size(); j++) begin
            if (got_nib[j] != exp_nib[j]) begin
               report_mismatch("mii_rxd_o", 32'(exp_nib[j]), 32'(got_nib[j]));
            end
            if (got_er[j] != exp_er[j]) begin
               report_mismatch("mii_rx_er_o", 32'(exp_er[j]), 32'(got_er[j]));
            end
         end
      end
   endtask

   task automatic mii_tx_test();
      logic [1:0] exp_txd [0:63];
      logic       exp_en [0:63];
      logic       exp_ok [0:63];
      logic       prev_stb;
      logic [3:0] nib;
      logic       en;
      for (int c = 0; c < 64; c++) exp_ok[c] = 1'b0;
      @(negedge clk_i);
      prev_stb = mii_tx_stb_o;
      for (int c = 1; c < 60; c++) begin
         @(negedge clk_i);
         if (mii_tx_stb_o == prev_stb) report_failure("transmit strobe did not toggle");
         prev_stb = mii_tx_stb_o;
         if (exp_ok[c]) begin
            if (rmii_txd_o != exp_txd[c]) begin
               report_mismatch("rmii_txd_o", 32'(exp_txd[c]), 32'(rmii_txd_o));
            end
            if (rmii_txen_o != exp_en[c]) begin
               report_mismatch("rmii_txen_o", 32'(exp_en[c]), 32'(rmii_txen_o));
            end
         end
         if (!mii_tx_stb_o) begin
            nib = 4'(lfsr_bits(4));
            en  = lfsr_bits(3) != 0;
            exp_txd[c+2] = nib[1:0];
            exp_txd[c+3] = nib[3:2];
            exp_en[c+2]  = en;
            exp_en[c+3]  = en;
            exp_ok[c+2]  = 1'b1;
            exp_ok[c+3]  = 1'b1;
            @(posedge clk_i);
            mii_txd_i   <= nib;
            mii_tx_en_i <= en;
         end
      end
      @(posedge clk_i);
      mii_tx_en_i <= 1'b0;
   endtask

   initial begin
      logic [27:0] adr;
      logic [31:0] v, rd;
      logic        se;
      int          start;
      rst_i = 1'b1;
      wb_req = '0;
      awready_i = 1'b0;
      wready_i = 1'b0;
      arready_i = 1'b0;
      bvalid_i = 1'b0;
      rvalid_i = 1'b0;
      b_i = '0;
      r_i = '0;
      rmii_crsdv_i = 1'b0;
      rmii_rxerr_i = 1'b0;
      rmii_rxd_i = 2'b00;
      mii_txd_i = 4'h0;
      mii_tx_en_i = 1'b0;
      apb_req = '0;

      start = err_cnt;
      for (int i = 0; i < 11; i++) begin
         @(negedge clk_i);
         if (awvalid_o || wvalid_o || arvalid_o) report_failure("AXI valid high in reset");
         if (wb_rsp_o.ack || wb_rsp_o.err) report_failure("ack or err high in reset");
         if (mii_rx_dv_o || rmii_txen_o) report_failure("rx_dv or txen high in reset");
         if (apb_rsp_o.pslverr) report_failure("pslverr high in reset");
         if (rst_i && !(rst_sys_o && rst_cpu_o)) report_failure("reset outputs low in reset");
         if (i == 9) begin
            @(posedge clk_i);
            rst_i <= 1'b0;
         end
      end
      finish_test("reset", start);

      start = err_cnt;
      for (int n = 0; n < 40; n++) begin
         adr = {lfsr_bits(2) == 3, 25'(lfsr_bits(25)), 2'b00};
         if (!adr[27]) wr_addrs.push_back(adr);
         wb_access(1'b1, adr, lfsr_bits(32), 4'(lfsr_bits(4)));
      end
      finish_test("writes", start);

      start = err_cnt;
      for (int n = 0; n < 40; n++) begin
         adr = {lfsr_bits(2) == 3, 25'(lfsr_bits(25)), 2'b00};
         if (lfsr_bits(1) && wr_addrs.size() > 0) begin
            adr = wr_addrs[lfsr_bits(6) % wr_addrs.size()];
         end
         wb_access(1'b0, adr, 32'd0, 4'hF);
      end
      finish_test("reads", start);

      start = err_cnt;
      apb_xfer(1'b0, tile_sys_pkg::REG_ID, 32'd0, rd, se);
      if (rd != tile_sys_pkg::SYSTEM_ID) report_mismatch("prdata", tile_sys_pkg::SYSTEM_ID, rd);
      if (se) report_failure("slave error on an ID read");
      for (int n = 0; n < 4; n++) begin
         v = lfsr_bits(32);
         apb_xfer(1'b1, tile_sys_pkg::REG_SCRATCH, v, rd, se);
         apb_xfer(1'b0, tile_sys_pkg::REG_SCRATCH, 32'd0, rd, se);
         if (rd != v) report_mismatch("prdata", v, rd);
      end
      apb_xfer(1'b1, tile_sys_pkg::REG_ID, 32'hFFFF_FFFF, rd, se);
      if (!se) report_failure("no slave error on an ID write");
      apb_xfer(1'b0, 8'h0C, 32'd0, rd, se);
      if (!se) report_failure("no slave error on an unmapped read");
      apb_xfer(1'b1, 8'h40, 32'd1, rd, se);
      if (!se) report_failure("no slave error on an unmapped write");
      ctrl_write(2'b01);
      ctrl_write(2'b10);
      ctrl_write(2'b11);
      ctrl_write(2'b00);
      finish_test("debug registers", start);

      start = err_cnt;
      for (int n = 0; n < 3; n++) begin
         rmii_rx_frame(4 + int'(lfsr_bits(4)) % 13);
      end
      finish_test("rmii receive", start);

      start = err_cnt;
      mii_tx_test();
      finish_test("mii transmit", start);

      $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- verilog/tile_board_top.sv
// Board level top with the DRAM bridge, the Ethernet adapter and debug control
`timescale 1ns/1ps

module tile_board_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Tile memory port
   input  tile_sys_pkg::wb_req_t  wb_req_i,
   output tile_sys_pkg::wb_rsp_t  wb_rsp_o,
   // DRAM AXI master
   output tile_sys_pkg::axi_ax_t  aw_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,
   output tile_sys_pkg::axi_w_t   w_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,
   input  tile_sys_pkg::axi_b_t   b_i,
   input  logic                   bvalid_i,
   output logic                   bready_o,
   output tile_sys_pkg::axi_ax_t  ar_o,
   output logic                   arvalid_o,
   input  logic                   arready_i,
   input  tile_sys_pkg::axi_r_t   r_i,
   input  logic                   rvalid_i,
   output logic                   rready_o,
   // Ethernet PHY and tile MII
   input  logic                   rmii_crsdv_i,
   input  logic                   rmii_rxerr_i,
   input  logic [1:0]             rmii_rxd_i,
   output logic [1:0]             rmii_txd_o,
   output logic                   rmii_txen_o,
   output logic [3:0]             mii_rxd_o,
   output logic                   mii_rx_dv_o,
   output logic                   mii_rx_er_o,
   input  logic [3:0]             mii_txd_i,
   input  logic                   mii_tx_en_i,
   output logic                   mii_tx_stb_o,
   // Host debug port
   input  tile_sys_pkg::apb_req_t apb_req_i,
   output tile_sys_pkg::apb_rsp_t apb_rsp_o,
   output logic                   rst_sys_o,
   output logic                   rst_cpu_o
);

   wb_to_axi_bridge u_wb_to_axi_bridge (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wb_req_i  (wb_req_i),
      .wb_rsp_o  (wb_rsp_o),
      .aw_o      (aw_o),
      .awvalid_o (awvalid_o),
      .awready_i (awready_i),
      .w_o       (w_o),
      .wvalid_o  (wvalid_o),
      .wready_i  (wready_i),
      .b_i       (b_i),
      .bvalid_i  (bvalid_i),
      .bready_o  (bready_o),
      .ar_o      (ar_o),
      .arvalid_o (arvalid_o),
      .arready_i (arready_i),
      .r_i       (r_i),
      .rvalid_i  (rvalid_i),
      .rready_o  (rready_o)
   );

   rmii_mii_adapter u_rmii_mii_adapter (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .rmii_crsdv_i (rmii_crsdv_i),
      .rmii_rxerr_i (rmii_rxerr_i),
      .rmii_rxd_i   (rmii_rxd_i),
      .rmii_txd_o   (rmii_txd_o),
      .rmii_txen_o  (rmii_txen_o),
      .mii_rxd_o    (mii_rxd_o),
      .mii_rx_dv_o  (mii_rx_dv_o),
      .mii_rx_er_o  (mii_rx_er_o),
      .mii_txd_i    (mii_txd_i),
      .mii_tx_en_i  (mii_tx_en_i),
      .mii_tx_stb_o (mii_tx_stb_o)
   );

   dbg_ctrl_apb u_dbg_ctrl_apb (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .rst_sys_o (rst_sys_o),
      .rst_cpu_o (rst_cpu_o)
   );

endmodule

//--- verilog/dbg_ctrl_apb.sv
// APB debug control registers with system ID, scratch word and reset requests
`timescale 1ns/1ps

module dbg_ctrl_apb (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  tile_sys_pkg::apb_req_t apb_req_i,
   output tile_sys_pkg::apb_rsp_t apb_rsp_o,
   output logic                   rst_sys_o,
   output logic                   rst_cpu_o
);

   // Bit 0 system reset request, bit 1 CPU reset request
   logic [1:0]                          ctrl_q;
   logic [tile_sys_pkg::DATA_WIDTH-1:0] scratch_q;

   logic                                access;
   logic                                wr_en;
   logic [tile_sys_pkg::DATA_WIDTH-1:0] rdata;
   logic                                bad_access;

   assign access = apb_req_i.psel && apb_req_i.penable;
   assign wr_en  = access && apb_req_i.pwrite && !bad_access;

   always_comb begin
      rdata      = '0;
      bad_access = 1'b0;
      case (apb_req_i.paddr)
         tile_sys_pkg::REG_CTRL: begin
            rdata[1:0] = ctrl_q;
         end
         tile_sys_pkg::REG_ID: begin
            rdata      = tile_sys_pkg::SYSTEM_ID;
            // Read only
            bad_access = apb_req_i.pwrite;
         end
         tile_sys_pkg::REG_SCRATCH: begin
            rdata = scratch_q;
         end
         default: begin
            bad_access = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_q    <= 2'b00;
         scratch_q <= '0;
      end else if (wr_en) begin
         if (apb_req_i.paddr == tile_sys_pkg::REG_CTRL) begin
            ctrl_q <= apb_req_i.pwdata[1:0];
         end
         if (apb_req_i.paddr == tile_sys_pkg::REG_SCRATCH) begin
            scratch_q <= apb_req_i.pwdata;
         end
      end
   end

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = access && bad_access;

   // Board reset merged with the debug requests
   assign rst_sys_o = rst_i || ctrl_q[0];
   assign rst_cpu_o = rst_i || ctrl_q[1];

endmodule

//--- verilog/rmii_mii_adapter.sv
// RMII dibit to MII nibble adapter with a transmit strobe in the system clock
`timescale 1ns/1ps

module rmii_mii_adapter (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       rmii_crsdv_i,
   input  logic       rmii_rxerr_i,
   input  logic [1:0] rmii_rxd_i,
   output logic [1:0] rmii_txd_o,
   output logic       rmii_txen_o,
   output logic [3:0] mii_rxd_o,
   output logic       mii_rx_dv_o,
   output logic       mii_rx_er_o,
   input  logic [3:0] mii_txd_i,
   input  logic       mii_tx_en_i,
   output logic       mii_tx_stb_o
);

   // Receive side
   logic       rx_phase_q;
   logic       rx_dv_q;
   logic       rx_er_q;
   logic [1:0] rx_lo_q;
   logic       rx_er_lo_q;
   logic [3:0] rxd_q;

   // Transmit side
   logic       tx_stb_q;
   logic       txen_q;
   logic [1:0] txd_q;
   logic [1:0] tx_hi_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rx_phase_q <= 1'b0;
         rx_dv_q    <= 1'b0;
         rx_er_q    <= 1'b0;
      end else begin
         // A dropped crsdv throws away a half nibble
         rx_phase_q <= rmii_crsdv_i && !rx_phase_q;
         rx_dv_q    <= rmii_crsdv_i && rx_phase_q;
         rx_er_q    <= rmii_crsdv_i && rx_phase_q && (rmii_rxerr_i || rx_er_lo_q);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rmii_crsdv_i && !rx_phase_q) begin
         rx_lo_q    <= rmii_rxd_i;
         rx_er_lo_q <= rmii_rxerr_i;
      end
      if (rmii_crsdv_i && rx_phase_q) begin
         rxd_q <= {rmii_rxd_i, rx_lo_q};
      end
   end

   assign mii_rxd_o   = rxd_q;
   assign mii_rx_dv_o = rx_dv_q;
   assign mii_rx_er_o = rx_er_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         tx_stb_q <= 1'b0;
         txen_q   <= 1'b0;
      end else begin
         tx_stb_q <= !tx_stb_q;
         if (tx_stb_q) begin
            txen_q <= mii_tx_en_i;
         end
      end
   end

   // Low dibit first, high dibit on the following cycle
   always_ff @(posedge clk_i) begin
      if (tx_stb_q) begin
         txd_q   <= mii_txd_i[1:0];
         tx_hi_q <= mii_txd_i[3:2];
      end else begin
         txd_q <= tx_hi_q;
      end
   end

   assign mii_tx_stb_o = tx_stb_q;
   assign rmii_txd_o   = txd_q;
   assign rmii_txen_o  = txen_q;

endmodule

//--- verilog/wb_to_axi_bridge.sv
// Wishbone classic single-access to AXI4 master bridge for external DRAM
`timescale 1ns/1ps

module wb_to_axi_bridge (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  tile_sys_pkg::wb_req_t wb_req_i,
   output tile_sys_pkg::wb_rsp_t wb_rsp_o,
   output tile_sys_pkg::axi_ax_t aw_o,
   output logic                 awvalid_o,
   input  logic                 awready_i,
   output tile_sys_pkg::axi_w_t  w_o,
   output logic                 wvalid_o,
   input  logic                 wready_i,
   input  tile_sys_pkg::axi_b_t  b_i,
   input  logic                 bvalid_i,
   output logic                 bready_o,
   output tile_sys_pkg::axi_ax_t ar_o,
   output logic                 arvalid_o,
   input  logic                 arready_i,
   input  tile_sys_pkg::axi_r_t  r_i,
   input  logic                 rvalid_i,
   output logic                 rready_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_RESP,
      ST_DONE
   } state_t;

   state_t state_q;

   logic awvalid_q;
   logic wvalid_q;
   logic arvalid_q;
   logic ack_q;
   logic err_q;

   // Captured request and read data
   logic [tile_sys_pkg::ADDR_WIDTH-1:0] adr_q;
   logic [tile_sys_pkg::DATA_WIDTH-1:0] wdat_q;
   logic [tile_sys_pkg::SEL_WIDTH-1:0]  sel_q;
   logic                                we_q;
   logic [tile_sys_pkg::DATA_WIDTH-1:0] rdat_q;

   logic req_seen;
   logic aw_left;
   logic w_left;
   logic addr_done;
   logic rsp_fire;
   logic rsp_okay;

   assign req_seen = wb_req_i.cyc && wb_req_i.stb;

   // Still waiting on AW or W after this cycle
   assign aw_left   = awvalid_q && !awready_i;
   assign w_left    = wvalid_q && !wready_i;
   assign addr_done = we_q ? (!aw_left && !w_left) : (!arvalid_q || arready_i);

   assign rsp_fire = we_q ? bvalid_i : rvalid_i;
   assign rsp_okay = we_q ? (b_i.resp == tile_sys_pkg::AXI_RESP_OKAY)
                          : (r_i.resp == tile_sys_pkg::AXI_RESP_OKAY);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q   <= ST_IDLE;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         arvalid_q <= 1'b0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (req_seen) begin
                  awvalid_q <= wb_req_i.we;
                  wvalid_q  <= wb_req_i.we;
                  arvalid_q <= !wb_req_i.we;
                  state_q   <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               // AW and W may be accepted in either order
               awvalid_q <= aw_left;
               wvalid_q  <= w_left;
               arvalid_q <= arvalid_q && !arready_i;
               if (addr_done) begin
                  state_q <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (rsp_fire) begin
                  ack_q   <= rsp_okay;
                  err_q   <= !rsp_okay;
                  state_q <= ST_DONE;
               end
            end
            default: begin
               // Hold off until the tile drops its request
               if (!req_seen) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && req_seen) begin
         adr_q  <= wb_req_i.adr;
         wdat_q <= wb_req_i.dat;
         sel_q  <= wb_req_i.sel;
         we_q   <= wb_req_i.we;
      end
      if (state_q == ST_RESP && !we_q && rvalid_i) begin
         rdat_q <= r_i.data;
      end
   end

   // Single-beat word transfers with a fixed ID
   assign aw_o.id    = tile_sys_pkg::AXI_ID;
   assign aw_o.addr  = adr_q;
   assign aw_o.len   = 8'd0;
   assign aw_o.size  = tile_sys_pkg::AXI_SIZE_WORD;
   assign aw_o.burst = tile_sys_pkg::AXI_BURST_INCR;
   assign ar_o       = aw_o;

   assign w_o.data = wdat_q;
   assign w_o.strb = sel_q;
   assign w_o.last = 1'b1;

   assign awvalid_o = awvalid_q;
   assign wvalid_o  = wvalid_q;
   assign arvalid_o = arvalid_q;
   assign bready_o  = (state_q == ST_RESP) && we_q;
   assign rready_o  = (state_q == ST_RESP) && !we_q;

   assign wb_rsp_o.dat = rdat_q;
   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.err = err_q;

endmodule

//--- verilog/tile_sys_pkg.sv
// Memory and APB widths, AXI codes, debug register map and packed bus structs
package tile_sys_pkg;

   localparam int ADDR_WIDTH     = 28;
   localparam int DATA_WIDTH     = 32;
   localparam int SEL_WIDTH      = 4;
   localparam int AXI_ID_WIDTH   = 4;
   localparam int APB_ADDR_WIDTH = 8;

   localparam logic [AXI_ID_WIDTH-1:0] AXI_ID         = '0;
   localparam logic [2:0]              AXI_SIZE_WORD  = 3'd2;
   localparam logic [1:0]              AXI_BURST_INCR = 2'd1;
   localparam logic [1:0]              AXI_RESP_OKAY  = 2'd0;

   localparam logic [DATA_WIDTH-1:0] SYSTEM_ID = 32'h0001_0001;

   // Debug register offsets
   localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL    = 8'h00;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_ID      = 8'h04;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_SCRATCH = 8'h08;

   typedef struct packed {
      logic [ADDR_WIDTH-1:0] adr;
      logic [DATA_WIDTH-1:0] dat;
      logic [SEL_WIDTH-1:0]  sel;
      logic                  we;
      logic                  cyc;
      logic                  stb;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] dat;
      logic                  ack;
      logic                  err;
   } wb_rsp_t;

   // Shared by AW and AR
   typedef struct packed {
      logic [AXI_ID_WIDTH-1:0] id;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [7:0]              len;
      logic [2:0]              size;
      logic [1:0]              burst;
   } axi_ax_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [SEL_WIDTH-1:0]  strb;
      logic                  last;
   } axi_w_t;

   typedef struct packed {
      logic [AXI_ID_WIDTH-1:0] id;
      logic [1:0]              resp;
   } axi_b_t;

   typedef struct packed {
      logic [AXI_ID_WIDTH-1:0] id;
      logic [DATA_WIDTH-1:0]   data;
      logic [1:0]              resp;
      logic                    last;
   } axi_r_t;

   typedef struct packed {
      logic [APB_ADDR_WIDTH-1:0] paddr;
      logic                      psel;
      logic                      penable;
      logic                      pwrite;
      logic [DATA_WIDTH-1:0]     pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

endpackage
